//--- include/nbf_config.svh
`ifndef NBF_CONFIG_SVH
`define NBF_CONFIG_SVH

////////////////////////////////////////
// frame geometry
////////////////////////////////////////

// signed width of each half, re and im
`define NBF_SAMPLE_W 16

// bins per fft frame, one bank per channel
`define NBF_FRAME_LEN 64

// index width, log2 of frame length
`define NBF_BIN_W 6

////////////////////////////////////////
// peak search
////////////////////////////////////////

// low bins below this one are never a peak
`define NBF_START_BIN 3

`endif

//--- rtl/nbf_pkg.sv
`include "nbf_config.svh"

package nbf_pkg;

  ////////////////////////////////////////
  // one complex fft bin, two views
  ////////////////////////////////////////

  typedef struct packed {
    logic signed [`NBF_SAMPLE_W-1:0] re;  // upper half
    logic signed [`NBF_SAMPLE_W-1:0] im;  // lower half
  } cplx_part_t;

  typedef union packed {
    logic [2*`NBF_SAMPLE_W-1:0] raw;      // as stored in the frame bank
    cplx_part_t                 part;     // as used for power
  } cplx_word_u;

  ////////////////////////////////////////
  // derived scalars
  ////////////////////////////////////////

  // re^2 + im^2 needs one bit over 2*w
  typedef logic [2*`NBF_SAMPLE_W:0] power_t;

  // bin index inside one frame
  typedef logic [`NBF_BIN_W-1:0] bin_t;

endpackage

//--- rtl/peak_search.sv
`timescale 1ns/100ps
`include "nbf_config.svh"

module peak_search import nbf_pkg::*; (
  input  logic       clk,            // sample clock
  input  logic       arst_n_i,       // async reset, active low
  input  cplx_word_u sample_i,       // fft bin, re in upper half
  input  logic       sample_en_i,    // one strobe per bin
  input  logic       sample_last_i,  // comes with bin 63
  output bin_t       peak_bin_o,     // held until next frame
  output logic       peak_valid_o    // single cycle pulse
);

  localparam bin_t START_BIN = bin_t'(`NBF_START_BIN);

  logic signed [2*`NBF_SAMPLE_W-1:0] re_sq;  // never negative
  logic signed [2*`NBF_SAMPLE_W-1:0] im_sq;
  power_t pwr_d;     // exact integer power
  bin_t   bin_cnt;   // index of incoming bin
  power_t pwr_q;     // stage 1 power
  bin_t   bin_q;     // stage 1 bin
  logic   vld_q;     // stage 1 strobe
  logic   last_q;    // stage 1 last flag
  power_t max_pwr;   // running maximum
  bin_t   max_bin;   // bin of running maximum
  logic   new_max;   // stage 1 bin beats the maximum

  ////////////////////////////////////////
  // stage 1: power and bin index
  ////////////////////////////////////////

  assign re_sq = sample_i.part.re * sample_i.part.re;
  assign im_sq = sample_i.part.im * sample_i.part.im;
  assign pwr_d = {1'b0, re_sq} + {1'b0, im_sq};  // zero extend, both squares >= 0

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bin_cnt <= '0;
      vld_q   <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      vld_q  <= sample_en_i;
      last_q <= sample_en_i && sample_last_i;
      if (sample_en_i) begin
        bin_cnt <= sample_last_i ? '0 : bin_cnt + 1'b1;  // next frame restarts at 0
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample_en_i) begin
      pwr_q <= pwr_d;    // payload only
      bin_q <= bin_cnt;
    end
  end

  ////////////////////////////////////////
  // stage 2: running maximum
  ////////////////////////////////////////

  // strictly greater, so the earliest bin keeps a tie
  assign new_max = vld_q && (bin_q >= START_BIN) && (pwr_q > max_pwr);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      max_pwr      <= '0;
      max_bin      <= START_BIN;
      peak_bin_o   <= '0;
      peak_valid_o <= 1'b0;
    end else begin
      peak_valid_o <= vld_q && last_q;              // 2 cycles after last strobe
      if (vld_q && last_q) begin
        peak_bin_o <= new_max ? bin_q : max_bin;    // last bin may still win
        max_pwr    <= '0;                           // fresh search next frame
        max_bin    <= START_BIN;
      end else if (new_max) begin
        max_pwr <= pwr_q;
        max_bin <= bin_q;
      end
    end
  end

endmodule

//--- rtl/frame_store.sv
`timescale 1ns/100ps
`include "nbf_config.svh"

module frame_store import nbf_pkg::*; (
  input  logic       clk,        // sample clock
  input  logic       wr_en_i,    // one write per input bin
  input  bin_t       wr_addr_i,  // bin index of the write
  input  cplx_word_u mea_wr_i,   // measurement word
  input  cplx_word_u ref_wr_i,   // reference word
  input  bin_t       rd_addr_i,  // replay address
  output cplx_word_u mea_rd_o,   // one cycle after rd_addr_i
  output cplx_word_u ref_rd_o    // one cycle after rd_addr_i
);

  localparam int DEPTH = `NBF_FRAME_LEN;

  ////////////////////////////////////////
  // one bank per channel
  ////////////////////////////////////////

  logic [2*`NBF_SAMPLE_W-1:0] mea_mem [DEPTH];  // raw words, measurement
  logic [2*`NBF_SAMPLE_W-1:0] ref_mem [DEPTH];  // raw words, reference

  // both channels share the write strobe and address
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mea_mem[wr_addr_i] <= mea_wr_i.raw;  // kept as bits, no decode
      ref_mem[wr_addr_i] <= ref_wr_i.raw;
    end
  end

  ////////////////////////////////////////
  // registered read
  ////////////////////////////////////////

  // read every cycle, the caller tracks which data is live
  always_ff @(posedge clk) begin
    mea_rd_o.raw <= mea_mem[rd_addr_i];  // latency 1
    ref_rd_o.raw <= ref_mem[rd_addr_i];
  end

  // a new frame overwrites the bank in place,
  // so the writer waits until the replay has drained

endmodule

//--- rtl/band_replay.sv
`timescale 1ns/100ps
`include "nbf_config.svh"

module band_replay import nbf_pkg::*; (
  input  logic       clk,               // sample clock
  input  logic       arst_n_i,          // async reset, active low
  input  logic       sample_en_i,       // one strobe per bin
  input  logic       sample_last_i,     // comes with bin 63
  input  cplx_word_u mea_sample_i,      // measurement bin
  input  cplx_word_u ref_sample_i,      // reference bin
  input  bin_t       ref_peak_bin_i,    // valid with the strobe
  input  logic       ref_peak_valid_i,  // starts the replay
  input  bin_t       band_width_i,      // half-width, sampled on the strobe
  output cplx_word_u mea_out_o,         // gated measurement
  output cplx_word_u ref_out_o,         // gated reference
  output logic       out_valid_o,       // 64 cycles per frame
  output logic       out_last_o         // with bin 63
);

  localparam bin_t LAST_BIN = bin_t'(`NBF_FRAME_LEN - 1);

  bin_t                wr_cnt;     // write address
  logic [`NBF_BIN_W:0] hi_sum;     // peak + width, one spare bit
  bin_t                lo_d;       // clamped band start
  bin_t                hi_d;       // clamped band end
  bin_t                band_lo;    // latched band start
  bin_t                band_hi;    // latched band end
  logic                rd_active;  // replay running
  bin_t                rd_addr;    // replay address
  logic                in_band_q;  // aligned with read data
  cplx_word_u          mea_rd;     // store output
  cplx_word_u          ref_rd;

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_cnt <= '0;
    end else if (sample_en_i) begin
      wr_cnt <= sample_last_i ? '0 : wr_cnt + 1'b1;  // gaps just hold the count
    end
  end

  frame_store u_frame_store (
    .clk       (clk),
    .wr_en_i   (sample_en_i),
    .wr_addr_i (wr_cnt),
    .mea_wr_i  (mea_sample_i),
    .ref_wr_i  (ref_sample_i),
    .rd_addr_i (rd_addr),
    .mea_rd_o  (mea_rd),
    .ref_rd_o  (ref_rd)
  );

  ////////////////////////////////////////
  // band limits
  ////////////////////////////////////////

  assign hi_sum = {1'b0, ref_peak_bin_i} + {1'b0, band_width_i};
  assign lo_d   = (ref_peak_bin_i > band_width_i) ? ref_peak_bin_i - band_width_i : '0;
  assign hi_d   = (hi_sum > {1'b0, LAST_BIN}) ? LAST_BIN : hi_sum[`NBF_BIN_W-1:0];

  ////////////////////////////////////////
  // replay sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      band_lo   <= '0;
      band_hi   <= '0;
      rd_active <= 1'b0;
      rd_addr   <= '0;
    end else if (ref_peak_valid_i) begin
      band_lo   <= lo_d;             // reference band, used on both channels
      band_hi   <= hi_d;
      rd_active <= 1'b1;
      rd_addr   <= '0;               // first cycle reads bin 0
    end else if (rd_active) begin
      rd_addr   <= rd_addr + 1'b1;   // wraps to 0 after bin 63
      if (rd_addr == LAST_BIN) begin
        rd_active <= 1'b0;
      end
    end
  end

  // flags follow the read by one cycle, same as the store
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_o <= 1'b0;
      out_last_o  <= 1'b0;
      in_band_q   <= 1'b0;
    end else begin
      out_valid_o <= rd_active;
      out_last_o  <= rd_active && (rd_addr == LAST_BIN);
      in_band_q   <= rd_active && (rd_addr >= band_lo) && (rd_addr <= band_hi);
    end
  end

  ////////////////////////////////////////
  // output gating
  ////////////////////////////////////////

  assign mea_out_o = (out_valid_o && in_band_q) ? mea_rd : '0;  // zero outside band
  assign ref_out_o = (out_valid_o && in_band_q) ? ref_rd : '0;  // zero when idle

endmodule

//--- rtl/nbf_top.sv
`timescale 1ns/100ps

module nbf_top import nbf_pkg::*; (
  input  logic       clk,             // sample clock
  input  logic       arst_n_i,        // async reset, active low
  input  cplx_word_u mea_sample_i,    // measurement channel bin
  input  cplx_word_u ref_sample_i,    // reference channel bin
  input  logic       sample_en_i,     // shared strobe, both channels aligned
  input  logic       sample_last_i,   // with bin 63
  input  bin_t       band_width_i,    // band half-width
  output bin_t       mea_peak_bin_o,  // measurement peak
  output bin_t       ref_peak_bin_o,  // reference peak
  output cplx_word_u mea_out_o,       // filtered measurement frame
  output cplx_word_u ref_out_o,       // filtered reference frame
  output logic       out_valid_o,     // replay strobe
  output logic       out_last_o       // last replayed bin
);

  logic ref_peak_valid;  // reference peak ready, drives the replay

  ////////////////////////////////////////
  // peak search, one per channel
  ////////////////////////////////////////

  // measurement result moves with the reference strobe,
  // both searches see the same strobes so they finish together
  peak_search mea_peak_search (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .sample_i      (mea_sample_i),
    .sample_en_i   (sample_en_i),
    .sample_last_i (sample_last_i),
    .peak_bin_o    (mea_peak_bin_o),
    .peak_valid_o  ()                // only the reference strobe is used
  );

  peak_search ref_peak_search (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .sample_i      (ref_sample_i),
    .sample_en_i   (sample_en_i),
    .sample_last_i (sample_last_i),
    .peak_bin_o    (ref_peak_bin_o),
    .peak_valid_o  (ref_peak_valid)  // 2 cycles after last strobe
  );

  ////////////////////////////////////////
  // buffered replay with band gating
  ////////////////////////////////////////

  // out_valid_o lands 4 cycles after the last input strobe
  band_replay u_band_replay (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .sample_en_i      (sample_en_i),
    .sample_last_i    (sample_last_i),
    .mea_sample_i     (mea_sample_i),
    .ref_sample_i     (ref_sample_i),
    .ref_peak_bin_i   (ref_peak_bin_o),  // band centre
    .ref_peak_valid_i (ref_peak_valid),
    .band_width_i     (band_width_i),
    .mea_out_o        (mea_out_o),
    .ref_out_o        (ref_out_o),
    .out_valid_o      (out_valid_o),
    .out_last_o       (out_last_o)
  );

endmodule

//--- tb/nbf_assert.sv
`timescale 1ns/100ps

module nbf_assert import nbf_pkg::*; (
  input logic       clk,           // sample clock
  input logic       arst_n_i,      // async reset, active low
  input logic       peak_valid_i,  // reference peak strobe
  input logic       out_valid_i,   // replay strobe
  input logic       out_last_i,    // last replayed bin
  input cplx_word_u mea_out_i,     // gated measurement
  input cplx_word_u ref_out_i      // gated reference
);

  ////////////////////////////////////////
  // replay output rules
  ////////////////////////////////////////

  last_needs_valid : assert property (@(posedge clk) disable iff (!arst_n_i)
    out_last_i |-> out_valid_i)
    else $error("out_last_o is high while out_valid_o is low");

  idle_outputs_zero : assert property (@(posedge clk) disable iff (!arst_n_i)
    !out_valid_i |-> (mea_out_i.raw == '0) && (ref_out_i.raw == '0))
    else $error("replay data is not zero while out_valid_o is low");

  // two stages between the peak strobe and the first word
  valid_after_peak : assert property (@(posedge clk) disable iff (!arst_n_i)
    $past(peak_valid_i, 2) |-> $rose(out_valid_i))
    else $error("out_valid_o did not rise 2 cycles after the peak strobe");

  valid_needs_peak : assert property (@(posedge clk) disable iff (!arst_n_i)
    $rose(out_valid_i) |-> $past(peak_valid_i, 2))
    else $error("out_valid_o rose without a peak strobe 2 cycles before");

endmodule

bind band_replay nbf_assert u_nbf_assert (
  .clk          (clk),
  .arst_n_i     (arst_n_i),
  .peak_valid_i (ref_peak_valid_i),
  .out_valid_i  (out_valid_o),
  .out_last_i   (out_last_o),
  .mea_out_i    (mea_out_o),
  .ref_out_i    (ref_out_o)
);

//--- tb/nbf_tb.sv
`timescale 1ns/100ps
`include "nbf_config.svh"

module nbf_tb import nbf_pkg::*; ();

  localparam int SW        = `NBF_SAMPLE_W;
  localparam int FRAME_LEN = `NBF_FRAME_LEN;
  localparam int START_BIN = `NBF_START_BIN;
  localparam int N_ROWS    = 6;
  localparam int OUT_DELAY = 4;                                // last strobe to first word
  localparam int TIMEOUT   = N_ROWS * (FRAME_LEN * 2 + 70 + 10);

  ////////////////////////////////////////
  // stimulus table, one row per frame
  ////////////////////////////////////////

  //                                      0     1     2    3    4     5
  localparam int ROW_REF_TONE [N_ROWS] = '{20,   20,   4,   63,  1,    33};
  localparam int ROW_MEA_TONE [N_ROWS] = '{40,   40,   10,  63,  2,    50};
  localparam int ROW_AMP      [N_ROWS] = '{1000, 1000, 800, 500, 2000, 300};
  localparam int ROW_WIDTH    [N_ROWS] = '{4,    4,    9,   5,   3,    0};
  localparam bit ROW_GAPPED   [N_ROWS] = '{0,    1,    0,   1,   0,    1};
  // row 1 repeats row 0 with gaps, row 4 hides both tones below the start bin

  logic       clk;
  logic       arst_n_i;
  cplx_word_u mea_sample_i;
  cplx_word_u ref_sample_i;
  logic       sample_en_i;
  logic       sample_last_i;
  bin_t       band_width_i;
  bin_t       mea_peak_bin_o;
  bin_t       ref_peak_bin_o;
  cplx_word_u mea_out_o;
  cplx_word_u ref_out_o;
  logic       out_valid_o;
  logic       out_last_o;

  int mea_re [FRAME_LEN];  // copy of the frame in flight
  int mea_im [FRAME_LEN];
  int ref_re [FRAME_LEN];
  int ref_im [FRAME_LEN];
  int check_cnt;
  int err_cnt;
  int cycle_cnt;

  nbf_top UUT (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .mea_sample_i   (mea_sample_i),
    .ref_sample_i   (ref_sample_i),
    .sample_en_i    (sample_en_i),
    .sample_last_i  (sample_last_i),
    .band_width_i   (band_width_i),
    .mea_peak_bin_o (mea_peak_bin_o),
    .ref_peak_bin_o (ref_peak_bin_o),
    .mea_out_o      (mea_out_o),
    .ref_out_o      (ref_out_o),
    .out_valid_o    (out_valid_o),
    .out_last_o     (out_last_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic int noise_value();
    return int'($urandom % 7) - 3;  // -3 .. 3
  endfunction

  function automatic logic [2*SW-1:0] pack_word(input int re, input int im);
    return {re[SW-1:0], im[SW-1:0]};  // re in upper half
  endfunction

  // argmax over bins from the start bin, first bin keeps a tie
  function automatic int expected_peak(input bit use_ref);
    longint best_pwr;
    longint pwr;
    int     best_bin;
    best_pwr = 0;
    best_bin = START_BIN;
    for (int b = START_BIN; b < FRAME_LEN; b++) begin
      if (use_ref) begin
        pwr = longint'(ref_re[b]) * ref_re[b] + longint'(ref_im[b]) * ref_im[b];
      end else begin
        pwr = longint'(mea_re[b]) * mea_re[b] + longint'(mea_im[b]) * mea_im[b];
      end
      if (pwr > best_pwr) begin
        best_pwr = pwr;
        best_bin = b;
      end
    end
    return best_bin;
  endfunction

  function automatic int band_lo(input int peak, input int width);
    int lo;
    lo = peak - width;
    if (lo < 0) begin
      lo = 0;  // clamp at bin 0
    end
    return lo;
  endfunction

  function automatic int band_hi(input int peak, input int width);
    int hi;
    hi = peak + width;
    if (hi > FRAME_LEN - 1) begin
      hi = FRAME_LEN - 1;  // clamp at the last bin
    end
    return hi;
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [2*SW-1:0] got,
                             input logic [2*SW-1:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_idle();
    check_value("out_valid_o", out_valid_o, 1'b0);
    check_value("out_last_o", out_last_o, 1'b0);
    check_value("mea_out_o", mea_out_o.raw, '0);
    check_value("ref_out_o", ref_out_o.raw, '0);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic build_frame(input int row);
    for (int b = 0; b < FRAME_LEN; b++) begin
      mea_re[b] = noise_value();  // background floor
      mea_im[b] = noise_value();
      ref_re[b] = noise_value();
      ref_im[b] = noise_value();
    end
    ref_re[ROW_REF_TONE[row]] = ROW_AMP[row];
    ref_im[ROW_REF_TONE[row]] = -ROW_AMP[row] / 2;
    mea_re[ROW_MEA_TONE[row]] = ROW_AMP[row] / 2;
    mea_im[ROW_MEA_TONE[row]] = ROW_AMP[row];
  endtask

  task automatic drive_frame(input int row);
    band_width_i <= bin_t'(ROW_WIDTH[row]);  // held until the next row
    for (int b = 0; b < FRAME_LEN; b++) begin
      if (ROW_GAPPED[row] && (b % 8 == 5)) begin
        mea_sample_i.raw <= $urandom;          // junk on an idle cycle
        ref_sample_i.raw <= $urandom;
        sample_en_i      <= 1'b0;
        sample_last_i    <= 1'b0;
        @(posedge clk);
      end
      mea_sample_i.raw <= pack_word(mea_re[b], mea_im[b]);
      ref_sample_i.raw <= pack_word(ref_re[b], ref_im[b]);
      sample_en_i      <= 1'b1;
      sample_last_i    <= (b == FRAME_LEN - 1);
      @(posedge clk);
    end
    sample_en_i   <= 1'b0;
    sample_last_i <= 1'b0;
  endtask

  task automatic check_replay(input int row);
    int          ref_pk;
    int          mea_pk;
    int          lo;
    int          hi;
    int          wait_cnt;
    logic [2*SW-1:0] mea_exp;
    logic [2*SW-1:0] ref_exp;
    ref_pk   = expected_peak(1'b1);
    mea_pk   = expected_peak(1'b0);
    lo       = band_lo(ref_pk, ROW_WIDTH[row]);
    hi       = band_hi(ref_pk, ROW_WIDTH[row]);
    wait_cnt = 0;
    do begin
      @(negedge clk);  // outputs settled mid cycle
      wait_cnt++;
    end while (!out_valid_o && wait_cnt < 2 * OUT_DELAY);
    check_cnt++;
    assert (out_valid_o) else begin
      err_cnt++;
      $display("frame %0d: the replay never started", row);
    end
    check_value("out_valid_o delay", wait_cnt, OUT_DELAY);
    check_value("ref_peak_bin_o", ref_peak_bin_o, ref_pk);
    check_value("mea_peak_bin_o", mea_peak_bin_o, mea_pk);
    for (int i = 0; i < FRAME_LEN; i++) begin
      if ((i >= lo) && (i <= hi)) begin
        mea_exp = pack_word(mea_re[i], mea_im[i]);
        ref_exp = pack_word(ref_re[i], ref_im[i]);
      end else begin
        mea_exp = '0;  // outside the reference band
        ref_exp = '0;
      end
      check_value("out_valid_o", out_valid_o, 1'b1);
      check_value("out_last_o", out_last_o, i == FRAME_LEN - 1);
      check_value("mea_out_o", mea_out_o.raw, mea_exp);
      check_value("ref_out_o", ref_out_o.raw, ref_exp);
      @(negedge clk);
    end
    check_idle();  // exactly 64 words
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(87));
    check_cnt        = 0;
    err_cnt          = 0;
    arst_n_i         = 1'b0;
    mea_sample_i.raw = '0;
    ref_sample_i.raw = '0;
    sample_en_i      = 1'b0;
    sample_last_i    = 1'b0;
    band_width_i     = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_idle();
    check_value("mea_peak_bin_o", mea_peak_bin_o, '0);
    check_value("ref_peak_bin_o", ref_peak_bin_o, '0);
    @(posedge clk);
    arst_n_i <= 1'b1;  // released on the 5th edge
    repeat (2) @(posedge clk);
    for (int r = 0; r < N_ROWS; r++) begin
      build_frame(r);
      drive_frame(r);
      check_replay(r);
      repeat (6) @(posedge clk);  // keeps 70 cycles between frames
    end
    $display("%0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- list.f
+incdir+include
rtl/nbf_pkg.sv
rtl/peak_search.sv
rtl/frame_store.sv
rtl/band_replay.sv
rtl/nbf_top.sv
tb/nbf_assert.sv
tb/nbf_tb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module nbf_tb -f list.f -o nbf_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/nbf_sim > sim.log 2>&1
grep -q ">>> FAIL" sim.log \
  && { echo "simulation failed, see sim.log"; exit 1; }
grep -q ">>> PASS" sim.log \
  || { echo "simulation stopped without a result, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
